// File: fetch_pkg.sv
package fetch_pkg;

  // bundle and line geometry
  localparam int instr_w    = 32;  // bits per instruction
  localparam int ss_width   = 4;   // slots per decode bundle
  localparam int line_bytes = 64;  // bytes per cache line

  localparam int pc_w     = 64;
  localparam int line_w   = line_bytes * 8;
  localparam int offset_w = $clog2(line_bytes);

  typedef logic [instr_w-1:0]  instr_t;   // one instruction word
  typedef logic [pc_w-1:0]     pc_t;      // program counter
  typedef logic [line_w-1:0]   line_t;    // byte 0 sits in bits 7:0
  typedef logic [offset_w-1:0] offset_t;  // byte offset of a pc inside its line

  // nop that pads slots running past the end of the line
  localparam instr_t fill_instr = 32'hD503201F;

  // controller states
  typedef enum logic [1:0] {
    fs_idle,      // nothing outstanding
    fs_wait_l1i,  // waiting for the l1i line of a miss
    fs_discard    // a flushed l1i return is still on its way
  } fetch_state_e;

endpackage

// File: line_aligner.sv
`timescale 1ns/10ps

module line_aligner #(
  parameter int instr_w    = fetch_pkg::instr_w,
  parameter int ss_width   = fetch_pkg::ss_width,
  parameter int line_bytes = fetch_pkg::line_bytes
) (
  input  fetch_pkg::offset_t offset,
  input  fetch_pkg::line_t   line,
  output fetch_pkg::instr_t  instrs [ss_width]
);

  import fetch_pkg::*;

  localparam int instr_bytes = instr_w / 8;
  // wide enough to hold offset + last slot start + one instruction without wrapping
  localparam int start_w = $clog2(line_bytes + ss_width * instr_bytes) + 1;

  for (genvar i = 0; i < ss_width; i++) begin : g_slot
    logic [start_w-1:0] byte_start;  // first byte of this slot
    logic [start_w-1:0] byte_end;    // one past the last byte
    logic               in_line;

    assign byte_start = start_w'(offset) + start_w'(i * instr_bytes);
    assign byte_end   = byte_start + start_w'(instr_bytes);

    // slot must fit completely inside the line
    assign in_line = (byte_end <= start_w'(line_bytes));

    // line is little endian so a straight part select already puts
    // the lowest byte into bits 7:0
    always_comb begin
      if (in_line) begin
        instrs[i] = line[byte_start*8 +: instr_w];
      end else begin
        instrs[i] = fill_instr;  // fell off the end of the line
      end
    end
  end

endmodule

// File: fetch_control.sv
`timescale 1ns/10ps

module fetch_control #(
  parameter int instr_w  = fetch_pkg::instr_w,
  parameter int ss_width = fetch_pkg::ss_width
) (
  input  logic              clk_in,
  input  logic              rst_N_in,
  input  logic              flush_in,
  input  logic              pc_valid,
  input  logic              l0_valid,
  input  logic              l1i_valid,
  input  fetch_pkg::pc_t    pred_pc,
  input  fetch_pkg::instr_t l0_instrs [ss_width],
  input  fetch_pkg::instr_t l1i_instrs [ss_width],
  input  logic              decode_ready,
  output fetch_pkg::pc_t    miss_pc,
  output fetch_pkg::instr_t fetched_instrs [ss_width],
  output logic              fetch_valid,
  output logic              fetch_ready,
  output fetch_pkg::pc_t    next_pc
);

  import fetch_pkg::*;

  fetch_state_e state;
  fetch_state_e state_next;

  logic [1:0] stale_cnt;    // flushed l1i returns still to swallow
  logic [1:0] stale_next;
  logic       miss_queued;  // live miss taken while stale returns are pending
  logic       queued_next;
  pc_t        miss_pc_next;

  logic req_ok;    // a request can be taken this cycle
  logic hit;
  logic miss;
  logic take_l1i;  // l1i return that belongs to the live miss

  logic [instr_w-1:0] instrs_next [ss_width];
  logic               valid_next;
  logic               ready_next;
  pc_t                pc_next;

  // no new request while a live miss is outstanding, and none on a flush
  assign req_ok = pc_valid & ~flush_in &
                  ((state == fs_idle) | ((state == fs_discard) & ~miss_queued));
  assign hit      = req_ok & l0_valid;
  assign miss     = req_ok & ~l0_valid;
  assign take_l1i = l1i_valid & (state == fs_wait_l1i) & ~flush_in;

  // miss tracking and discard bookkeeping
  always_comb begin
    state_next   = state;
    stale_next   = stale_cnt;
    queued_next  = miss_queued;
    miss_pc_next = miss_pc;

    unique case (state)
      fs_idle: begin
        if (miss) begin
          miss_pc_next = pred_pc;
          state_next   = fs_wait_l1i;
        end
      end

      fs_wait_l1i: begin
        if (flush_in) begin
          if (l1i_valid) begin
            state_next = fs_idle;  // line showed up on the flush edge itself, dropped
          end else begin
            state_next = fs_discard;
            stale_next = 2'd1;
          end
        end else if (l1i_valid) begin
          state_next = fs_idle;
        end
      end

      fs_discard: begin
        if (l1i_valid) begin
          stale_next = stale_next - 2'd1;  // eat one stale return
        end
        if (flush_in && miss_queued) begin
          stale_next  = stale_next + 2'd1;  // queued miss is now stale as well
          queued_next = 1'b0;
        end
        if (miss) begin
          miss_pc_next = pred_pc;
          queued_next  = 1'b1;
        end
        // all stale lines gone, the queued miss (if any) becomes the live one
        if (stale_next == 2'd0) begin
          state_next  = queued_next ? fs_wait_l1i : fs_idle;
          queued_next = 1'b0;
        end
      end

      default: begin
        state_next  = fs_idle;
        stale_next  = 2'd0;
        queued_next = 1'b0;
      end
    endcase
  end

  // bundle selection: flush, then l1i return, then l0 hit, else hold
  always_comb begin
    if (flush_in) begin
      for (int i = 0; i < ss_width; i++) begin
        instrs_next[i] = '0;
      end
      valid_next = 1'b0;
      pc_next    = next_pc;
    end else if (take_l1i) begin
      for (int i = 0; i < ss_width; i++) begin
        instrs_next[i] = l1i_instrs[i];
      end
      valid_next = 1'b1;
      pc_next    = miss_pc;
    end else if (hit) begin
      for (int i = 0; i < ss_width; i++) begin
        instrs_next[i] = l0_instrs[i];
      end
      valid_next = 1'b1;
      pc_next    = pred_pc;
    end else begin
      for (int i = 0; i < ss_width; i++) begin
        instrs_next[i] = fetched_instrs[i];  // keep last bundle, just not valid
      end
      valid_next = 1'b0;
      pc_next    = next_pc;
    end
  end

  // ready when nothing live is outstanding and the stale counter has headroom
  assign ready_next = (state_next == fs_idle) |
                      ((state_next == fs_discard) & ~queued_next & (stale_next != 2'd3));

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      state       <= fs_idle;
      stale_cnt   <= 2'd0;
      miss_queued <= 1'b0;
      fetch_valid <= 1'b0;
      fetch_ready <= 1'b0;
      next_pc     <= '0;
      for (int i = 0; i < ss_width; i++) begin
        fetched_instrs[i] <= '0;
      end
    end else if (decode_ready) begin  // decode stalls freeze everything
      state       <= state_next;
      stale_cnt   <= stale_next;
      miss_queued <= queued_next;
      fetch_valid <= valid_next;
      fetch_ready <= ready_next;
      next_pc     <= pc_next;
      for (int i = 0; i < ss_width; i++) begin
        fetched_instrs[i] <= instrs_next[i];
      end
    end
  end

  // pc of the live miss, steers the l1i aligner
  always_ff @(posedge clk_in) begin
    if (decode_ready) begin
      miss_pc <= miss_pc_next;
    end
  end

endmodule

// File: fetch_top.sv
`timescale 1ns/10ps

module fetch_top #(
  parameter int instr_w    = fetch_pkg::instr_w,
  parameter int ss_width   = fetch_pkg::ss_width,
  parameter int line_bytes = fetch_pkg::line_bytes
) (
  input  logic              clk_in,
  input  logic              rst_N_in,
  input  logic              flush_in,      // mispredict from the back end
  input  fetch_pkg::pc_t    pred_pc,       // predictor pc
  input  logic              pc_valid,
  input  logic              l0_valid,      // l0 line matches pred_pc
  input  fetch_pkg::line_t  l0_line,
  input  logic              l1i_valid,     // one cycle fill pulse
  input  fetch_pkg::line_t  l1i_line,
  input  logic              decode_ready,
  output fetch_pkg::instr_t fetched_instrs [ss_width],
  output logic              fetch_valid,
  output logic              fetch_ready,   // back to the predictor
  output fetch_pkg::pc_t    next_pc
);

  import fetch_pkg::*;

  offset_t l0_offset;
  offset_t l1i_offset;
  pc_t     miss_pc;

  instr_t l0_instrs  [ss_width];
  instr_t l1i_instrs [ss_width];

  // l0 path slices at the live pc, l1i path at the pc that missed
  assign l0_offset  = pred_pc[$bits(offset_t)-1:0];
  assign l1i_offset = miss_pc[$bits(offset_t)-1:0];

  line_aligner #(
    .instr_w    (instr_w),
    .ss_width   (ss_width),
    .line_bytes (line_bytes)
  ) l0_align (
    .offset (l0_offset),
    .line   (l0_line),
    .instrs (l0_instrs)
  );

  line_aligner #(
    .instr_w    (instr_w),
    .ss_width   (ss_width),
    .line_bytes (line_bytes)
  ) l1i_align (
    .offset (l1i_offset),
    .line   (l1i_line),
    .instrs (l1i_instrs)
  );

  fetch_control #(
    .instr_w  (instr_w),
    .ss_width (ss_width)
  ) ctrl (
    .clk_in         (clk_in),
    .rst_N_in       (rst_N_in),
    .flush_in       (flush_in),
    .pc_valid       (pc_valid),
    .l0_valid       (l0_valid),
    .l1i_valid      (l1i_valid),
    .pred_pc        (pred_pc),
    .l0_instrs      (l0_instrs),
    .l1i_instrs     (l1i_instrs),
    .decode_ready   (decode_ready),
    .miss_pc        (miss_pc),
    .fetched_instrs (fetched_instrs),
    .fetch_valid    (fetch_valid),
    .fetch_ready    (fetch_ready),
    .next_pc        (next_pc)
  );

endmodule

// File: tb_fetch_model.svh
`ifndef TB_FETCH_MODEL_SVH
`define TB_FETCH_MODEL_SVH

// expected bundle, slot i sits in bits [i*32 +: 32]
typedef logic [ss_width*instr_w-1:0] bundle_t;

localparam int          model_line_bytes = 64;
localparam logic [31:0] pad_word         = 32'hD503201F;  // nop placed past the line end

// expected decode bundle for a line sliced at a byte offset
function automatic bundle_t align_ref(input line_t line, input int offset);
  bundle_t res;
  int      first;
  res = '0;
  for (int slot = 0; slot < ss_width; slot++) begin
    first = offset + 4 * slot;
    if (first + 3 > model_line_bytes - 1) begin
      res[slot*32 +: 32] = pad_word;  // group would cross byte 63
    end else begin
      // little endian, lowest byte ends up in bits 7:0
      for (int b = 0; b < 4; b++) begin
        res[slot*32 + 8*b +: 8] = line[8*(first + b) +: 8];
      end
    end
  end
  return res;
endfunction

// cache line filled with random bytes
function automatic line_t random_line();
  line_t l;
  l = '0;
  for (int i = 0; i < model_line_bytes; i++) begin
    l[8*i +: 8] = 8'($urandom);
  end
  return l;
endfunction

// random byte offset inside a line
function automatic int random_offset();
  int off;
  off = int'($urandom % model_line_bytes);
  return off;
endfunction

// random pc whose low bits hold the given line offset
function automatic pc_t make_pc(input int offset);
  pc_t pc;
  pc = {$urandom, $urandom};
  pc[5:0] = 6'(offset);
  return pc;
endfunction

// offset of a pc inside its line, as the model sees it
function automatic int line_offset(input pc_t pc);
  int off;
  off = int'(pc[5:0]);
  return off;
endfunction

`endif

// File: tb_fetch.sv
`timescale 1ns/10ps

module tb_fetch;

  import fetch_pkg::*;

  localparam int clk_period = 40;
  localparam int n_hits     = 24;
  localparam int n_misses   = 10;
  localparam int n_flushes  = 4;
  localparam int n_bp       = 30;
  localparam int n_requests = 1 + n_hits + n_misses + n_flushes + n_bp;

  logic   clk_in;
  logic   rst_N_in;
  logic   flush_in;
  pc_t    pred_pc;
  logic   pc_valid;
  logic   l0_valid;
  line_t  l0_line;
  logic   l1i_valid;
  line_t  l1i_line;
  logic   decode_ready;
  instr_t fetched_instrs [ss_width];
  logic   fetch_valid;
  logic   fetch_ready;
  pc_t    next_pc;

  `include "tb_fetch_model.svh"

  bundle_t exp_bundle_q [$];  // bundles decode should see in order
  pc_t     exp_pc_q [$];
  int      errors    = 0;
  int      checks    = 0;
  int      delivered = 0;
  int      err_base  = 0;     // error count when the current test began
  bit      bp_on     = 1'b0;  // random decode stalls

  bundle_t last_bundle;
  pc_t     last_pc;
  logic    last_valid;
  bit      was_stalled = 1'b0;

  fetch_top #(
    .instr_w    (instr_w),
    .ss_width   (ss_width),
    .line_bytes (line_bytes)
  ) dut (
    .clk_in         (clk_in),
    .rst_N_in       (rst_N_in),
    .flush_in       (flush_in),
    .pred_pc        (pred_pc),
    .pc_valid       (pc_valid),
    .l0_valid       (l0_valid),
    .l0_line        (l0_line),
    .l1i_valid      (l1i_valid),
    .l1i_line       (l1i_line),
    .decode_ready   (decode_ready),
    .fetched_instrs (fetched_instrs),
    .fetch_valid    (fetch_valid),
    .fetch_ready    (fetch_ready),
    .next_pc        (next_pc)
  );

  initial begin
    clk_in = 1'b0;
    forever #(clk_period / 2) clk_in = ~clk_in;
  end

  initial begin
    #(n_requests * 40 * clk_period);
    $display("watchdog: run still busy after %0d cycles, stopping", n_requests * 40);
    $display("=== FAIL ===");
    $finish;
  end

  function automatic bundle_t dut_bundle();
    bundle_t b;
    for (int i = 0; i < ss_width; i++) begin
      b[i*instr_w +: instr_w] = fetched_instrs[i];
    end
    return b;
  endfunction

  // one clock edge that reports whether the dut took it
  task automatic tick(output bit taken);
    @(posedge clk_in);
    taken = decode_ready;
    if (bp_on) begin
      decode_ready <= (($urandom % 3) != 0);
    end else begin
      decode_ready <= 1'b1;
    end
  endtask

  task automatic until_taken();
    bit taken;
    taken = 1'b0;
    while (!taken) tick(taken);
  endtask

  // at least one edge, then until the registered ready is high
  task automatic wait_ready();
    bit taken;
    tick(taken);
    while (fetch_ready !== 1'b1) tick(taken);
  endtask

  task automatic expect_not_ready();
    checks++;
    if (fetch_ready !== 1'b0) begin
      $display("error: fetch_ready got %h expected %h", fetch_ready, 1'b0);
      errors++;
    end
  endtask

  // the edge just taken loads the bundle, so it shows one cycle later
  task automatic expect_valid_next();
    bit taken;
    tick(taken);
    checks++;
    if (fetch_valid !== 1'b1) begin
      $display("error: fetch_valid got %h expected %h", fetch_valid, 1'b1);
      errors++;
    end
  endtask

  task automatic send_hit(input int off);
    line_t line;
    pc_t   pc;
    line = random_line();
    pc   = make_pc(off);
    wait_ready();
    pred_pc  <= pc;
    pc_valid <= 1'b1;
    l0_valid <= 1'b1;
    l0_line  <= line;
    until_taken();
    exp_bundle_q.push_back(align_ref(line, off));
    exp_pc_q.push_back(pc);
    pc_valid <= 1'b0;
    l0_valid <= 1'b0;
    expect_valid_next();
  endtask

  task automatic send_miss(input int delay);
    line_t line;
    pc_t   pc;
    bit    taken;
    line = random_line();
    pc   = make_pc(random_offset());
    wait_ready();
    pred_pc  <= pc;
    pc_valid <= 1'b1;
    l0_valid <= 1'b0;
    until_taken();
    pc_valid <= 1'b0;
    pred_pc  <= make_pc(random_offset());  // l1i path must follow the missed pc
    repeat (delay) begin
      tick(taken);
      expect_not_ready();
    end
    l1i_line  <= line;
    l1i_valid <= 1'b1;
    taken = 1'b0;
    while (!taken) begin
      tick(taken);
      expect_not_ready();
    end
    exp_bundle_q.push_back(align_ref(line, line_offset(pc)));
    exp_pc_q.push_back(pc);
    l1i_valid <= 1'b0;
    expect_valid_next();
  endtask

  // miss, flush while it waits, then the stale fill and one hit
  task automatic flush_miss(input bit hit_first);
    pc_t   pc;
    line_t stale_line;
    bit    taken;
    pc = make_pc(random_offset());
    stale_line = random_line();
    wait_ready();
    pred_pc  <= pc;
    pc_valid <= 1'b1;
    l0_valid <= 1'b0;
    until_taken();
    pc_valid <= 1'b0;
    repeat (1 + $urandom % 4) tick(taken);
    flush_in <= 1'b1;
    until_taken();
    flush_in <= 1'b0;
    tick(taken);
    checks++;
    if (fetch_valid !== 1'b0) begin
      $display("error: fetch_valid got %h expected %h", fetch_valid, 1'b0);
      errors++;
    end
    if (dut_bundle() !== '0) begin
      $display("error: fetched_instrs got %h expected %h", dut_bundle(), bundle_t'(0));
      errors++;
    end
    if (hit_first) send_hit(random_offset());  // accepted while the discard is pending
    l1i_line  <= stale_line;
    l1i_valid <= 1'b1;
    until_taken();
    l1i_valid <= 1'b0;
    if (!hit_first) send_hit(random_offset());
  endtask

  task automatic drain();
    bit taken;
    while (exp_pc_q.size() != 0) tick(taken);
    tick(taken);
    tick(taken);
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %s: %0d errors", num, name, errors - err_base);
    err_base = errors;
  endtask

  // compares each bundle decode takes, and checks outputs hold over stalls
  always @(posedge clk_in) begin : check_outputs
    bundle_t got;
    bundle_t want;
    pc_t     want_pc;
    got = dut_bundle();
    if (rst_N_in !== 1'b0) begin
      was_stalled = 1'b0;
    end else begin
      if (was_stalled) begin
        checks++;
        if (fetch_valid !== last_valid) begin
          $display("error: fetch_valid got %h expected %h", fetch_valid, last_valid);
          errors++;
        end
        if (next_pc !== last_pc) begin
          $display("error: next_pc got %h expected %h", next_pc, last_pc);
          errors++;
        end
        if (got !== last_bundle) begin
          $display("error: fetched_instrs got %h expected %h", got, last_bundle);
          errors++;
        end
      end
      if (fetch_valid === 1'b1 && decode_ready === 1'b1) begin
        if (exp_pc_q.size() == 0) begin
          $display("bundle for next_pc %h delivered with nothing outstanding", next_pc);
          errors++;
        end else begin
          want    = exp_bundle_q.pop_front();
          want_pc = exp_pc_q.pop_front();
          checks++;
          delivered++;
          if (got !== want) begin
            $display("error: fetched_instrs got %h expected %h", got, want);
            errors++;
          end
          if (next_pc !== want_pc) begin
            $display("error: next_pc got %h expected %h", next_pc, want_pc);
            errors++;
          end
        end
      end
      last_bundle = got;
      last_pc     = next_pc;
      last_valid  = fetch_valid;
      was_stalled = (decode_ready === 1'b0);
    end
  end

  initial begin
    bit taken;
    int off;
    void'($urandom(33));
    rst_N_in     <= 1'b1;
    flush_in     <= 1'b0;
    pred_pc      <= '0;
    pc_valid     <= 1'b0;
    l0_valid     <= 1'b0;
    l0_line      <= '0;
    l1i_valid    <= 1'b0;
    l1i_line     <= '0;
    decode_ready <= 1'b1;

    repeat (5) tick(taken);
    rst_N_in <= 1'b0;
    tick(taken);  // sees the values the reset left behind
    checks++;
    if (fetch_valid !== 1'b0) begin
      $display("error: fetch_valid got %h expected %h", fetch_valid, 1'b0);
      errors++;
    end
    if (fetch_ready !== 1'b0) begin
      $display("error: fetch_ready got %h expected %h", fetch_ready, 1'b0);
      errors++;
    end
    if (next_pc !== '0) begin
      $display("error: next_pc got %h expected %h", next_pc, pc_t'(0));
      errors++;
    end
    end_test(1, "reset values");

    for (int i = 0; i < n_hits; i++) begin
      off = (i < 4) ? 63 - 4 * i : random_offset();  // first few land on the line end
      send_hit(off);
    end
    drain();
    end_test(2, "l0 hits");

    for (int i = 0; i < n_misses; i++) begin
      send_miss(int'($urandom % 12));
    end
    drain();
    end_test(3, "l1i misses");

    for (int i = 0; i < n_flushes; i++) begin
      flush_miss(i[0]);
    end
    drain();
    end_test(4, "flush during miss");

    bp_on = 1'b1;
    for (int i = 0; i < n_bp; i++) begin
      if (($urandom % 3) == 0) begin
        send_miss(int'($urandom % 6));
      end else begin
        send_hit(random_offset());
      end
    end
    drain();
    bp_on = 1'b0;
    end_test(5, "decode back-pressure");

    $display("summary: %0d checks, %0d bundles delivered, %0d errors",
             checks, delivered, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+.
fetch_pkg.sv
line_aligner.sv
fetch_control.sv
fetch_top.sv
tb_fetch.sv

// File: run.sh
#!/bin/sh
# build the fetch testbench with verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 -Wno-fatal --top-module tb_fetch -f tb.f \
  && ./obj_dir/Vtb_fetch | tee /dev/stderr | grep -qx "=== PASS ===" \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }
